// File: verilog/videogen_pkg.sv
package videogen_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	// Pixel index from the tile/sprite mixer
	localparam int INDEX_W = 8;

	// Bank bit sits above the index
	localparam int PAL_ADDR_W = INDEX_W + 1;

	// Entries per PROM lane
	localparam int PAL_DEPTH = 1 << PAL_ADDR_W;

	// One resistor DAC per channel
	localparam int COLOR_W = 4;

	// Full colour word, blue/green/red
	localparam int WORD_W = 3 * COLOR_W;

	// Red/green PROM is a byte wide
	localparam int RG_W = 2 * COLOR_W;

	//////////////////////////////////////////////////
	// Colour word
	//////////////////////////////////////////////////

	// CPU side writes raw, video side picks channels
	typedef union packed {
		logic [WORD_W-1:0] raw;
		struct packed {
			logic [COLOR_W-1:0] blue;
			logic [COLOR_W-1:0] green;
			logic [COLOR_W-1:0] red;
		} ch;
	} color_word_u;

endpackage

// File: verilog/video_timing.sv
`timescale 1ns/1ps

module video_timing #(
	parameter int H_ACTIVE    = 32,
	parameter int H_TOTAL     = 48,
	parameter int HSYNC_START = 36,
	parameter int HSYNC_WIDTH = 4,
	parameter int V_ACTIVE    = 8,
	parameter int V_TOTAL     = 12,
	parameter int VSYNC_START = 9,
	parameter int VSYNC_WIDTH = 1
) (
	input  logic clk_6md,
	input  logic rst,
	output logic hblank,
	output logic vblank,
	output logic hsync,
	output logic vsync,
	output logic line_end,
	output logic frame_end
);

	localparam int H_W = $clog2(H_TOTAL);
	localparam int V_W = $clog2(V_TOTAL);

	// Raster position
	logic [H_W-1:0] h_cnt;
	logic [V_W-1:0] v_cnt;

	// Position after the coming edge
	logic [H_W-1:0] h_next;
	logic [V_W-1:0] v_next;

	logic line_last;
	logic frame_last;

	//////////////////////////////////////////////////
	// Next position
	//////////////////////////////////////////////////

	// line_end marks the last pixel, so wrap there
	always_comb begin
		if (line_end) begin
			h_next = '0;
		end else begin
			h_next = h_cnt + 1'b1;
		end
	end

	// Vertical steps once per line
	always_comb begin
		v_next = v_cnt;
		if (frame_end) begin
			v_next = '0;
		end else if (line_end) begin
			v_next = v_cnt + 1'b1;
		end
	end

	// Last pixel and last line, seen one edge early
	assign line_last  = (h_next == H_W'(H_TOTAL - 1));
	assign frame_last = line_last && (v_next == V_W'(V_TOTAL - 1));

	//////////////////////////////////////////////////
	// Counters and decoded outputs
	//////////////////////////////////////////////////

	// Outputs decode the next position, so they line up with the counters
	always_ff @(posedge clk_6md) begin
		if (rst) begin
			h_cnt     <= '0;
			v_cnt     <= '0;
			hblank    <= 1'b0;
			vblank    <= 1'b0;
			hsync     <= 1'b0;
			vsync     <= 1'b0;
			line_end  <= 1'b0;
			frame_end <= 1'b0;
		end else begin
			h_cnt     <= h_next;
			v_cnt     <= v_next;
			hblank    <= (h_next >= H_ACTIVE);
			vblank    <= (v_next >= V_ACTIVE);
			// Sync windows in pixels and in whole lines
			hsync     <= (h_next >= HSYNC_START) && (h_next < HSYNC_START + HSYNC_WIDTH);
			vsync     <= (v_next >= VSYNC_START) && (v_next < VSYNC_START + VSYNC_WIDTH);
			line_end  <= line_last;
			frame_end <= frame_last;
		end
	end

	// Sync pulse stays inside horizontal blanking
	a_hsync_in_blank: assert property (@(posedge clk_6md) disable iff (rst)
		hsync |-> hblank);

	// Frame end is a line end and line zero follows
	a_frame_end_wrap: assert property (@(posedge clk_6md) disable iff (rst)
		frame_end |-> line_end ##1 (!vblank && !frame_end));

endmodule

// File: verilog/frame_fsm.sv
`timescale 1ns/1ps

module frame_fsm #(
	parameter int H_TOTAL  = 48,
	parameter int V_ACTIVE = 8,
	parameter int V_TOTAL  = 12
) (
	input  logic clk_6md,
	input  logic rst,
	input  logic vblank,
	input  logic frame_end,
	input  logic bank_req,
	input  logic pal_we,
	output logic bank,
	output logic pal_wr_en,
	output logic pal_busy
);

	// Visible area, palette locked
	localparam logic ST_ACTIVE = 1'b0;
	// Vertical blank, palette open
	localparam logic ST_VBLANK = 1'b1;

	// Clocks from first blank line to end of frame
	localparam int VB_CYCLES = (V_TOTAL - V_ACTIVE) * H_TOTAL;

	logic state;
	logic state_next;
	logic vb_entry;

	//////////////////////////////////////////////////
	// State transitions
	//////////////////////////////////////////////////

	// First clock of vertical blanking
	assign vb_entry = (state == ST_ACTIVE) && vblank;

	always_comb begin
		state_next = state;
		case (state)
			ST_ACTIVE: begin
				if (vblank) begin
					state_next = ST_VBLANK;
				end
			end
			ST_VBLANK: begin
				// Back to locked for the first visible line
				if (frame_end) begin
					state_next = ST_ACTIVE;
				end
			end
			default: begin
				state_next = ST_ACTIVE;
			end
		endcase
	end

	// State and bank latch
	always_ff @(posedge clk_6md) begin
		if (rst) begin
			state <= ST_ACTIVE;
			bank  <= 1'b0;
		end else begin
			state <= state_next;
			// Bank request sampled once per frame
			if (vb_entry) begin
				bank <= bank_req;
			end
		end
	end

	//////////////////////////////////////////////////
	// CPU write gate
	//////////////////////////////////////////////////

	assign pal_busy = (state == ST_ACTIVE);

	// Strobe passes only in the window, otherwise lost
	assign pal_wr_en = pal_we && !pal_busy;

	// Bank only moves on entry to blanking
	a_bank_hold: assert property (@(posedge clk_6md) disable iff (rst)
		!$stable(bank) |-> (state == ST_VBLANK));

	// Writes land only while the raster is in vertical blank
	a_wr_in_vblank: assert property (@(posedge clk_6md) disable iff (rst)
		pal_wr_en |-> vblank);

	// Write window spans the whole blanking interval, no more
	a_window_len: assert property (@(posedge clk_6md) disable iff (rst)
		vb_entry |=> (state == ST_VBLANK)[*VB_CYCLES - 1] ##1 (state == ST_ACTIVE));

endmodule

// File: verilog/palette_mem.sv
`timescale 1ns/1ps

module palette_mem (
	input  logic                              clk_6md,
	input  logic                              pal_wr_en,
	input  logic [videogen_pkg::PAL_ADDR_W-1:0] pal_addr,
	input  videogen_pkg::color_word_u         pal_wdata,
	input  logic [videogen_pkg::PAL_ADDR_W-1:0] rd_addr,
	output videogen_pkg::color_word_u         rd_data
);

	import videogen_pkg::*;

	//////////////////////////////////////////////////
	// Storage lanes
	//////////////////////////////////////////////////

	// Byte wide PROM, green high nibble, red low
	logic [RG_W-1:0] rg_lane [PAL_DEPTH];

	// Nibble wide PROM, blue
	logic [COLOR_W-1:0] b_lane [PAL_DEPTH];

	// Lane outputs at the lookup address
	logic [RG_W-1:0]    rg_rd;
	logic [COLOR_W-1:0] b_rd;

	// Split one CPU word over both lanes
	always_ff @(posedge clk_6md) begin
		if (pal_wr_en) begin
			rg_lane[pal_addr] <= {pal_wdata.ch.green, pal_wdata.ch.red};
			b_lane[pal_addr]  <= pal_wdata.ch.blue;
		end
	end

	//////////////////////////////////////////////////
	// Lookup
	//////////////////////////////////////////////////

	// Both lanes share one address, as on the board
	assign rg_rd = rg_lane[rd_addr];
	assign b_rd  = b_lane[rd_addr];

	// Rejoin lanes into one colour word
	always_comb begin
		rd_data.ch.blue  = b_rd;
		rd_data.ch.green = rg_rd[RG_W-1:COLOR_W];
		rd_data.ch.red   = rg_rd[COLOR_W-1:0];
	end

endmodule

// File: verilog/clut_stage.sv
`timescale 1ns/1ps

module clut_stage (
	input  logic                                clk_6md,
	input  logic                                rst,
	input  logic [videogen_pkg::INDEX_W-1:0]    pix_index,
	input  logic                                bank,
	input  logic                                blank_in,
	output logic [videogen_pkg::PAL_ADDR_W-1:0] rd_addr,
	input  videogen_pkg::color_word_u           rd_data,
	output logic [videogen_pkg::COLOR_W-1:0]    red,
	output logic [videogen_pkg::COLOR_W-1:0]    green,
	output logic [videogen_pkg::COLOR_W-1:0]    blue,
	output logic                                blank
);

	import videogen_pkg::*;

	// Stage 1, index latch and blank
	logic [INDEX_W-1:0] index_q;
	logic               blank_q;

	// Stage 2, output colour registers
	color_word_u rgb_q;

	//////////////////////////////////////////////////
	// Stage 1
	//////////////////////////////////////////////////

	// Index latch
	always_ff @(posedge clk_6md) begin
		index_q <= pix_index;
	end

	// Bank picks the upper or lower half of the palette
	assign rd_addr = {bank, index_q};

	//////////////////////////////////////////////////
	// Stage 2
	//////////////////////////////////////////////////

	// Blank follows the index through both stages
	always_ff @(posedge clk_6md) begin
		if (rst) begin
			blank_q <= 1'b1;
			blank   <= 1'b1;
			rgb_q   <= '0;
		end else begin
			blank_q <= blank_in;
			blank   <= blank_q;
			if (blank_q) begin
				// Black outside the visible area
				rgb_q <= '0;
			end else begin
				rgb_q.ch.red   <= rd_data.ch.red;
				rgb_q.ch.green <= rd_data.ch.green;
				rgb_q.ch.blue  <= rd_data.ch.blue;
			end
		end
	end

	// Channel registers to the DACs
	assign red   = rgb_q.ch.red;
	assign green = rgb_q.ch.green;
	assign blue  = rgb_q.ch.blue;

	// Blank at the input shows as black two clocks later
	a_blank_black: assert property (@(posedge clk_6md) disable iff (rst)
		blank_in |-> ##2 (blank && red == '0 && green == '0 && blue == '0));

endmodule

// File: verilog/videogen_top.sv
`timescale 1ns/1ps

module videogen_top #(
	parameter int H_ACTIVE    = 32,
	parameter int H_TOTAL     = 48,
	parameter int HSYNC_START = 36,
	parameter int HSYNC_WIDTH = 4,
	parameter int V_ACTIVE    = 8,
	parameter int V_TOTAL     = 12,
	parameter int VSYNC_START = 9,
	parameter int VSYNC_WIDTH = 1
) (
	input  logic                                clk_6md,
	input  logic                                rst,
	input  logic [videogen_pkg::INDEX_W-1:0]    pix_index,
	input  logic                                bank_req,
	input  logic                                pal_we,
	input  logic [videogen_pkg::PAL_ADDR_W-1:0] pal_addr,
	input  logic [videogen_pkg::WORD_W-1:0]     pal_wdata,
	output logic [videogen_pkg::COLOR_W-1:0]    red,
	output logic [videogen_pkg::COLOR_W-1:0]    green,
	output logic [videogen_pkg::COLOR_W-1:0]    blue,
	output logic                                hsync,
	output logic                                vsync,
	output logic                                blank,
	output logic                                pal_busy
);

	import videogen_pkg::*;

	// Raster timing
	logic hblank;
	logic vblank;
	logic frame_end;
	logic blank_in;

	// Frame control
	logic bank;
	logic pal_wr_en;

	// Lookup path
	logic [PAL_ADDR_W-1:0] rd_addr;
	color_word_u           rd_data;

	//////////////////////////////////////////////////
	// Raster and frame control
	//////////////////////////////////////////////////

	video_timing #(
		.H_ACTIVE   (H_ACTIVE),
		.H_TOTAL    (H_TOTAL),
		.HSYNC_START(HSYNC_START),
		.HSYNC_WIDTH(HSYNC_WIDTH),
		.V_ACTIVE   (V_ACTIVE),
		.V_TOTAL    (V_TOTAL),
		.VSYNC_START(VSYNC_START),
		.VSYNC_WIDTH(VSYNC_WIDTH)
	) video_timing_i (
		.clk_6md  (clk_6md),
		.rst      (rst),
		.hblank   (hblank),
		.vblank   (vblank),
		.hsync    (hsync),
		.vsync    (vsync),
		.line_end (),
		.frame_end(frame_end)
	);

	// Bank latch and CPU write window
	frame_fsm #(
		.H_TOTAL (H_TOTAL),
		.V_ACTIVE(V_ACTIVE),
		.V_TOTAL (V_TOTAL)
	) frame_fsm_i (
		.clk_6md  (clk_6md),
		.rst      (rst),
		.vblank   (vblank),
		.frame_end(frame_end),
		.bank_req (bank_req),
		.pal_we   (pal_we),
		.bank     (bank),
		.pal_wr_en(pal_wr_en),
		.pal_busy (pal_busy)
	);

	// Either blanking interval darkens the pixel
	assign blank_in = hblank | vblank;

	//////////////////////////////////////////////////
	// Palette and lookup
	//////////////////////////////////////////////////

	palette_mem palette_mem_i (
		.clk_6md  (clk_6md),
		.pal_wr_en(pal_wr_en),
		.pal_addr (pal_addr),
		.pal_wdata(pal_wdata),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data)
	);

	clut_stage clut_stage_i (
		.clk_6md  (clk_6md),
		.rst      (rst),
		.pix_index(pix_index),
		.bank     (bank),
		.blank_in (blank_in),
		.rd_addr  (rd_addr),
		.rd_data  (rd_data),
		.red      (red),
		.green    (green),
		.blue     (blue),
		.blank    (blank)
	);

endmodule

// File: bench/videogen_tb.sv
`timescale 1ns/1ps

module videogen_tb;

	// Raster sizes, same as the top level defaults
	localparam int H_ACTIVE    = 32;
	localparam int H_TOTAL     = 48;
	localparam int HSYNC_START = 36;
	localparam int HSYNC_WIDTH = 4;
	localparam int V_ACTIVE    = 8;
	localparam int V_TOTAL     = 12;
	localparam int VSYNC_START = 9;
	localparam int VSYNC_WIDTH = 1;
	localparam int FRAME       = H_TOTAL * V_TOTAL;
	localparam int LIMIT       = 3 * FRAME;

	logic        clk_6md;
	logic        rst;
	logic [7:0]  pix_index;
	logic        bank_req;
	logic        pal_we;
	logic [8:0]  pal_addr;
	logic [11:0] pal_wdata;
	logic [3:0]  red;
	logic [3:0]  green;
	logic [3:0]  blue;
	logic        hsync;
	logic        vsync;
	logic        blank;
	logic        pal_busy;

	// Reference palette and which entries hold known data
	logic [11:0] pal_ref [512];
	bit          pal_valid [512];

	// Raster and FSM model, advanced at each falling edge
	int   th;
	int   tv;
	int   cur_th;
	int   cur_tv;
	bit   m_vblank_st;
	bit   m_bank;
	// Lookup pipeline model
	logic [7:0]  st1_idx;
	bit          st1_blank;
	logic [11:0] exp_word;
	bit          exp_blank;
	bit          exp_valid;

	int errors;
	int checks;
	int tests_run;
	integer seed;

	videogen_top #(
		.H_ACTIVE   (H_ACTIVE),
		.H_TOTAL    (H_TOTAL),
		.HSYNC_START(HSYNC_START),
		.HSYNC_WIDTH(HSYNC_WIDTH),
		.V_ACTIVE   (V_ACTIVE),
		.V_TOTAL    (V_TOTAL),
		.VSYNC_START(VSYNC_START),
		.VSYNC_WIDTH(VSYNC_WIDTH)
	) dut_i (
		.clk_6md  (clk_6md),
		.rst      (rst),
		.pix_index(pix_index),
		.bank_req (bank_req),
		.pal_we   (pal_we),
		.pal_addr (pal_addr),
		.pal_wdata(pal_wdata),
		.red      (red),
		.green    (green),
		.blue     (blue),
		.hsync    (hsync),
		.vsync    (vsync),
		.blank    (blank),
		.pal_busy (pal_busy)
	);

	// 40 ns pixel clock
	initial begin
		clk_6md = 1'b0;
		forever #20 clk_6md = ~clk_6md;
	end

	////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic timeout_fail(input string what);
		$display("Timed out while waiting for %s", what);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	// Expected colour word, black when blanked
	function automatic logic [11:0] expected_color(input logic [7:0] idx, input bit bnk,
			input bit blk);
		if (blk) begin
			return 12'h000;
		end
		return pal_ref[{bnk, idx}];
	endfunction

	task automatic end_test(input int num, input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			$display("test %0d %s: %0d errors", num, name, errors - err_before);
		end
	endtask

	// Step to a settled point after the falling edge
	task automatic settle();
		@(negedge clk_6md);
		#1;
	endtask

	task automatic wait_position(input int line, input int pix);
		int n;
		n = 0;
		settle();
		while (!(cur_tv == line && cur_th == pix)) begin
			n++;
			if (n > LIMIT) begin
				timeout_fail("raster position");
			end
			settle();
		end
	endtask

	// Write one entry, holding off outside the open window
	task automatic write_word(input logic [8:0] addr, input logic [11:0] data);
		int n;
		n = 0;
		settle();
		while (pal_busy || (cur_th == H_TOTAL - 1 && cur_tv == V_TOTAL - 1)) begin
			n++;
			if (n > LIMIT) begin
				timeout_fail("palette write window");
			end
			@(posedge clk_6md);
			pal_we <= 1'b0;
			settle();
		end
		@(posedge clk_6md);
		pal_we    <= 1'b1;
		pal_addr  <= addr;
		pal_wdata <= data;
	endtask

	task automatic drive_random(input int count);
		repeat (count) begin
			@(posedge clk_6md);
			pix_index <= $random(seed);
		end
	endtask

	// Width and period of a sync pulse in clocks
	task automatic measure_pulse(input bit use_v, output int width, output int period);
		int n;
		n = 0;
		settle();
		while ((use_v ? vsync : hsync) !== 1'b0) begin
			n++;
			if (n > LIMIT) timeout_fail("sync low");
			settle();
		end
		while ((use_v ? vsync : hsync) !== 1'b1) begin
			n++;
			if (n > LIMIT) timeout_fail("sync rise");
			settle();
		end
		width  = 0;
		period = 0;
		while ((use_v ? vsync : hsync) === 1'b1) begin
			width++;
			period++;
			if (period > LIMIT) timeout_fail("sync fall");
			settle();
		end
		while ((use_v ? vsync : hsync) !== 1'b1) begin
			period++;
			if (period > LIMIT) timeout_fail("next sync rise");
			settle();
		end
	endtask

	////////////////////////////////////////////////////
	// Model and compare, on the falling edge
	////////////////////////////////////////////////////

	always @(negedge clk_6md) begin
		if (rst) begin
			th          = 0;
			tv          = 0;
			m_vblank_st = 1'b0;
			m_bank      = 1'b0;
			st1_blank   = 1'b1;
			exp_word    = 12'h000;
			exp_blank   = 1'b1;
			exp_valid   = 1'b1;
		end else begin
			cur_th = th;
			cur_tv = tv;
			// Outputs from the last rising edge
			check("blank", blank, exp_blank);
			check("hsync", hsync, th >= HSYNC_START && th < HSYNC_START + HSYNC_WIDTH);
			check("vsync", vsync, tv >= VSYNC_START && tv < VSYNC_START + VSYNC_WIDTH);
			check("pal_busy", pal_busy, !m_vblank_st);
			if (exp_valid) begin
				check("red", red, exp_word[3:0]);
				check("green", green, exp_word[7:4]);
				check("blue", blue, exp_word[11:8]);
			end
			// Colour registered at the coming edge
			exp_word  = expected_color(st1_idx, m_bank, st1_blank);
			exp_valid = st1_blank || pal_valid[{m_bank, st1_idx}];
			exp_blank = st1_blank;
			st1_idx   = pix_index;
			st1_blank = (th >= H_ACTIVE) || (tv >= V_ACTIVE);
			// Write accepted only while the window is open
			if (pal_we && m_vblank_st) begin
				pal_ref[pal_addr]   = pal_wdata;
				pal_valid[pal_addr] = 1'b1;
			end
			if (!m_vblank_st && tv >= V_ACTIVE) begin
				m_vblank_st = 1'b1;
				m_bank      = bank_req;
			end else if (m_vblank_st && th == H_TOTAL - 1 && tv == V_TOTAL - 1) begin
				m_vblank_st = 1'b0;
			end
			// Raster counters
			if (th == H_TOTAL - 1) begin
				th = 0;
				tv = (tv == V_TOTAL - 1) ? 0 : tv + 1;
			end else begin
				th = th + 1;
			end
		end
	end

	////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////

	initial begin
		int err0;
		int width;
		int period;
		seed      = 32'h2eee_127b;
		errors    = 0;
		checks    = 0;
		tests_run = 0;
		rst       = 1'b1;
		pix_index = 8'h00;
		bank_req  = 1'b0;
		pal_we    = 1'b0;
		pal_addr  = 9'h000;
		pal_wdata = 12'h000;
		repeat (2) @(posedge clk_6md);
		rst <= 1'b0;

		// 1: reset state
		err0 = errors;
		settle();
		check("red", red, 0);
		check("green", green, 0);
		check("blue", blue, 0);
		check("blank", blank, 1);
		check("hsync", hsync, 0);
		check("vsync", vsync, 0);
		check("pal_busy", pal_busy, 1);
		end_test(1, "reset state", err0);

		// 2: sync periods and widths
		err0 = errors;
		measure_pulse(1'b0, width, period);
		check("hsync width", width, HSYNC_WIDTH);
		check("hsync period", period, H_TOTAL);
		measure_pulse(1'b1, width, period);
		check("vsync width", width, VSYNC_WIDTH * H_TOTAL);
		check("vsync period", period, FRAME);
		end_test(2, "raster timing", err0);

		// 3: fill bank 0, then random lookups
		err0 = errors;
		for (int i = 0; i < 256; i++) begin
			write_word(9'(i), 12'($random(seed)));
		end
		@(posedge clk_6md);
		pal_we <= 1'b0;
		wait_position(0, 0);
		drive_random(FRAME);
		end_test(3, "palette lookup", err0);

		// 4: strobes in the active area are dropped
		err0 = errors;
		wait_position(1, 0);
		for (int i = 0; i < 8; i++) begin
			@(posedge clk_6md);
			pal_we    <= 1'b1;
			pal_addr  <= 9'(i);
			pal_wdata <= ~pal_ref[i];
			settle();
			check("pal_busy", pal_busy, 1);
		end
		@(posedge clk_6md);
		pal_we <= 1'b0;
		wait_position(2, 0);
		for (int i = 0; i < 8; i++) begin
			@(posedge clk_6md);
			pix_index <= 8'(i);
		end
		end_test(4, "refused writes", err0);

		// 5: fill bank 1, switch mid frame
		err0 = errors;
		for (int i = 0; i < 256; i++) begin
			write_word(9'(256 + i), 12'($random(seed)));
		end
		@(posedge clk_6md);
		pal_we <= 1'b0;
		wait_position(2, 0);
		@(posedge clk_6md);
		bank_req <= 1'b1;
		drive_random(2 * FRAME);
		end_test(5, "bank switching", err0);

		// 6: one whole frame including both blanking intervals
		err0 = errors;
		wait_position(V_ACTIVE - 1, 0);
		drive_random(FRAME + 4);
		end_test(6, "blanking", err0);

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: videogen.f
verilog/videogen_pkg.sv
verilog/video_timing.sv
verilog/frame_fsm.sv
verilog/palette_mem.sv
verilog/clut_stage.sv
verilog/videogen_top.sv
bench/videogen_tb.sv
